// File: verilog/cache_pkg.sv
package cache_pkg;

    localparam int INDEX_W   = 8;
    localparam int TAG_W     = 20;
    localparam int OFFSET_W  = 4;
    localparam int WORD_W    = 32;
    localparam int ADDR_W    = TAG_W + INDEX_W + OFFSET_W;
    localparam int NUM_BANKS = 4;
    localparam int BANK_W    = 2;
    localparam int LINE_W    = 128;
    localparam int NUM_SETS  = 256;
    localparam int NUM_WAYS  = 2;

    localparam int         LFSR_W    = 8;
    localparam logic [7:0] LFSR_SEED = 8'h01;
    localparam logic [7:0] LFSR_TAPS = 8'b1011_1000;  // bits 7,5,4,3

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } main_state_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } tag_entry_t;

    typedef logic [WORD_W-1:0] word_t;

    typedef struct packed {
        logic                  op;  // 1 = store
        logic [INDEX_W-1:0]    index;
        logic [TAG_W-1:0]      tag;
        logic [OFFSET_W-1:0]   offset;
        logic [WORD_W/8-1:0]   wstrb;
        word_t                 wdata;
    } cpu_req_t;

    // byte merge of store data over an existing word
    function automatic word_t merge_word(word_t old_word, word_t new_word,
                                         logic [WORD_W/8-1:0] strb);
        word_t res;
        res = old_word;
        for (int i = 0; i < WORD_W/8; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

// File: verilog/cache_array_if.sv
`timescale 1ns/1ps

interface cache_array_if import cache_pkg::*; ();

    // lookup side
    logic [INDEX_W-1:0] lookup_index;
    logic [TAG_W-1:0]   lookup_tag;
    logic [BANK_W-1:0]  lookup_bank;
    logic               hit;
    logic               hit_way;
    word_t              hit_word;

    // victim of the current miss
    logic               victim_way;
    logic               victim_dirty;
    logic [TAG_W-1:0]   victim_tag;
    logic [LINE_W-1:0]  victim_line;

    logic               refill_wen;
    logic [BANK_W-1:0]  refill_bank;
    word_t              refill_word;
    logic               refill_last;
    logic [TAG_W-1:0]   refill_tag;
    logic               refill_dirty;  // store miss leaves the line dirty

    logic               store_wen;
    logic               store_way;
    logic [INDEX_W-1:0] store_index;
    logic [BANK_W-1:0]  store_bank;
    word_t              store_word;

    modport ways (
        input  lookup_index, lookup_tag, lookup_bank,
        input  refill_wen, refill_bank, refill_word, refill_last, refill_tag, refill_dirty,
        input  store_wen, store_way, store_index, store_bank, store_word,
        output hit, hit_way, hit_word,
        output victim_way, victim_dirty, victim_tag, victim_line
    );

    modport ctrl (
        output lookup_index, lookup_tag, lookup_bank,
        output refill_wen, refill_bank, refill_word, refill_last, refill_tag, refill_dirty,
        input  hit, hit_word, victim_dirty, victim_tag, victim_line
    );

    modport store (
        output store_wen, store_way, store_index, store_bank, store_word
    );

endinterface

// File: verilog/cache_ram.sv
`timescale 1ns/1ps

module cache_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 256
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic                     wen,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem <= '{default: '0};  // whole array starts invalid
        end else begin
            if (wen) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];  // old data on a same-cycle write
        end
    end

endmodule

// File: verilog/cache_ways.sv
`timescale 1ns/1ps

module cache_ways import cache_pkg::*; (
    input  logic          clk,
    input  logic          resetn,
    cache_array_if.ways   arr
);

    logic [INDEX_W-1:0]  refill_index;  // row currently on the ram outputs
    logic [LFSR_W-1:0]   lfsr;
    logic [NUM_SETS-1:0] dirty [NUM_WAYS];
    logic [NUM_WAYS-1:0] way_hit;
    logic [INDEX_W-1:0]  tag_addr;
    logic                tag_wen_any;
    tag_entry_t          new_tag;
    tag_entry_t          tag_rd [NUM_WAYS];
    word_t               data_rd [NUM_WAYS][NUM_BANKS];

    always_ff @(posedge clk) begin
        refill_index <= arr.lookup_index;
    end

    assign tag_wen_any = arr.refill_wen && arr.refill_last;
    assign tag_addr    = arr.refill_wen ? refill_index : arr.lookup_index;
    assign new_tag     = '{tag: arr.refill_tag, valid: 1'b1};

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_tag
        cache_ram #(.entry_t(tag_entry_t), .DEPTH(NUM_SETS)) tag_ram (
            .clk   (clk),
            .resetn(resetn),
            .addr  (tag_addr),
            .wen   (tag_wen_any && arr.victim_way == 1'(w)),
            .wdata (new_tag),
            .rdata (tag_rd[w])
        );
        assign way_hit[w] = tag_rd[w].valid && tag_rd[w].tag == arr.lookup_tag;
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        logic               store_sel;
        logic               refill_sel;
        logic [INDEX_W-1:0] bank_addr;
        word_t              bank_wdata;

        // store write steals this bank's port for one cycle
        assign store_sel  = arr.store_wen && arr.store_bank == BANK_W'(b);
        assign refill_sel = arr.refill_wen && arr.refill_bank == BANK_W'(b);
        assign bank_addr  = store_sel ? arr.store_index :
                            arr.refill_wen ? refill_index : arr.lookup_index;
        assign bank_wdata = store_sel ? arr.store_word : arr.refill_word;

        for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
            cache_ram #(.entry_t(word_t), .DEPTH(NUM_SETS)) data_ram (
                .clk   (clk),
                .resetn(resetn),
                .addr  (bank_addr),
                .wen   ((store_sel && arr.store_way == 1'(w)) ||
                        (refill_sel && arr.victim_way == 1'(w))),
                .wdata (bank_wdata),
                .rdata (data_rd[w][b])
            );
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dirty <= '{default: '0};
        end else begin
            if (arr.store_wen) begin
                dirty[arr.store_way][arr.store_index] <= 1'b1;
            end
            if (tag_wen_any) begin
                dirty[arr.victim_way][refill_index] <= arr.refill_dirty;
            end
        end
    end

    // victim lfsr, steps once per finished refill
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= LFSR_SEED;
        end else if (tag_wen_any) begin
            lfsr <= {lfsr[LFSR_W-2:0], ^(lfsr & LFSR_TAPS)};
        end
    end

    assign arr.hit          = |way_hit;
    assign arr.hit_way      = way_hit[1];
    assign arr.hit_word     = data_rd[arr.hit_way][arr.lookup_bank];
    assign arr.victim_way   = lfsr[0];
    assign arr.victim_dirty = dirty[arr.victim_way][refill_index];
    assign arr.victim_tag   = tag_rd[arr.victim_way].tag;

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            arr.victim_line[b*WORD_W +: WORD_W] = data_rd[arr.victim_way][b];
        end
    end

endmodule

// File: verilog/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 valid,
    input  logic                 op,
    input  logic [INDEX_W-1:0]   index,
    input  logic [TAG_W-1:0]     tag,
    input  logic [OFFSET_W-1:0]  offset,
    input  logic [WORD_W/8-1:0]  wstrb,
    input  word_t                wdata,
    output logic                 addr_ok,
    output logic                 data_ok,
    output word_t                rdata,
    output logic                 rd_req,
    output logic [ADDR_W-1:0]    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  word_t                ret_data,
    output logic                 wr_req,
    output logic [ADDR_W-1:0]    wr_addr,
    output logic [LINE_W-1:0]    wr_data,
    input  logic                 wr_rdy,
    cache_array_if.ctrl          arr,
    output logic                 beat,
    input  logic [BANK_W-1:0]    beat_count,
    input  logic                 beat_crit,
    input  logic                 conflict,
    output cpu_req_t             req,
    output logic                 capture
);

    main_state_t state, state_nxt;
    logic        accept;
    logic        lookup_hit;
    logic        miss_settled;  // victim line re-read after a store port steal

    assign lookup_hit = state == LOOKUP && arr.hit;
    assign addr_ok    = resetn && (state == IDLE || lookup_hit) && !conflict;
    assign accept     = valid && addr_ok;
    assign capture    = lookup_hit && req.op;

    always_ff @(posedge clk) begin
        if (accept) begin
            req <= '{op: op, index: index, tag: tag, offset: offset, wstrb: wstrb, wdata: wdata};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= IDLE;
            miss_settled <= 1'b0;
        end else begin
            state        <= state_nxt;
            miss_settled <= state == MISS;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (accept) state_nxt = LOOKUP;
            LOOKUP: begin
                if (!arr.hit) begin
                    state_nxt = MISS;
                end else if (!accept) begin
                    state_nxt = IDLE;
                end
            end
            MISS:    if (!arr.victim_dirty || (miss_settled && wr_rdy)) state_nxt = REPLACE;
            REPLACE: if (rd_rdy) state_nxt = REFILL;
            REFILL:  if (ret_valid && ret_last) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // tags compare against the buffered request, data rams see the new index
    assign arr.lookup_index = (state == IDLE || lookup_hit) ? index : req.index;
    assign arr.lookup_tag   = req.tag;
    assign arr.lookup_bank  = req.offset[OFFSET_W-1 -: BANK_W];

    assign beat             = state == REFILL && ret_valid;
    assign arr.refill_wen   = beat;
    assign arr.refill_bank  = beat_count;
    assign arr.refill_last  = ret_last;
    assign arr.refill_tag   = req.tag;
    assign arr.refill_dirty = req.op;
    assign arr.refill_word  = (beat_crit && req.op) ?
                              merge_word(ret_data, req.wdata, req.wstrb) : ret_data;

    assign data_ok = (state == LOOKUP && (arr.hit || req.op)) ||
                     (beat && beat_crit && !req.op);  // critical word of a load miss
    assign rdata   = state == LOOKUP ? arr.hit_word : ret_data;

    assign rd_req  = state == REPLACE;
    assign rd_addr = {req.tag, req.index, {OFFSET_W{1'b0}}};
    assign wr_req  = state == MISS && miss_settled && arr.victim_dirty;
    assign wr_addr = {arr.victim_tag, req.index, {OFFSET_W{1'b0}}};
    assign wr_data = arr.victim_line;

endmodule

// File: verilog/refill_counter.sv
`timescale 1ns/1ps

module refill_counter import cache_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              beat,
    input  logic [BANK_W-1:0] crit_bank,
    output logic [BANK_W-1:0] count,
    output logic              crit
);

    logic last_beat;

    assign last_beat = count == BANK_W'(NUM_BANKS-1);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
        end else if (beat) begin
            if (last_beat) begin
                count <= '0;  // ready for the next line
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // beats arrive in bank order
    assign crit = beat && count == crit_bank;

endmodule

// File: verilog/store_buffer.sv
`timescale 1ns/1ps

module store_buffer import cache_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              capture,
    input  cpu_req_t          req,
    input  word_t             hit_word,
    input  logic              hit_way,
    input  logic              new_op,
    input  logic [BANK_W-1:0] new_bank,
    cache_array_if.store      arr,
    output logic              conflict
);

    logic               pend;
    logic               pend_way;
    logic [INDEX_W-1:0] pend_index;
    logic [BANK_W-1:0]  pend_bank;
    word_t              pend_word;
    logic [BANK_W-1:0]  req_bank;
    logic               forward;
    word_t              base_word;

    assign req_bank = req.offset[OFFSET_W-1 -: BANK_W];

    // back to back stores to one word, hit_word misses the pending bytes
    assign forward   = pend && pend_way == hit_way && pend_index == req.index &&
                       pend_bank == req_bank;
    assign base_word = forward ? pend_word : hit_word;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pend <= 1'b0;
        end else begin
            pend <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            pend_way   <= hit_way;
            pend_index <= req.index;
            pend_bank  <= req_bank;
            pend_word  <= merge_word(base_word, req.wdata, req.wstrb);
        end
    end

    assign arr.store_wen   = pend;
    assign arr.store_way   = pend_way;
    assign arr.store_index = pend_index;
    assign arr.store_bank  = pend_bank;
    assign arr.store_word  = pend_word;

    // load behind an unwritten store, or any access to the bank being written
    assign conflict = (capture && !new_op && new_bank == req_bank) ||
                      (pend && new_bank == pend_bank);

endmodule

// File: verilog/cache_top.sv
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
    input  logic                clk,
    input  logic                resetn,
    input  logic                valid,
    input  logic                op,
    input  logic [INDEX_W-1:0]  index,
    input  logic [TAG_W-1:0]    tag,
    input  logic [OFFSET_W-1:0] offset,
    input  logic [WORD_W/8-1:0] wstrb,
    input  word_t               wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output word_t               rdata,
    output logic                rd_req,
    output logic [ADDR_W-1:0]   rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  word_t               ret_data,
    output logic                wr_req,
    output logic [ADDR_W-1:0]   wr_addr,
    output logic [LINE_W-1:0]   wr_data,
    input  logic                wr_rdy
);

    logic              beat;
    logic [BANK_W-1:0] beat_count;
    logic              beat_crit;
    logic              conflict;
    logic              capture;
    cpu_req_t          req;

    cache_array_if arr ();

    cache_ctrl u_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .arr       (arr.ctrl),
        .beat      (beat),
        .beat_count(beat_count),
        .beat_crit (beat_crit),
        .conflict  (conflict),
        .req       (req),
        .capture   (capture)
    );

    refill_counter u_refill_counter (
        .clk      (clk),
        .resetn   (resetn),
        .beat     (beat),
        .crit_bank(req.offset[OFFSET_W-1 -: BANK_W]),
        .count    (beat_count),
        .crit     (beat_crit)
    );

    store_buffer u_store_buffer (
        .clk     (clk),
        .resetn  (resetn),
        .capture (capture),
        .req     (req),
        .hit_word(arr.hit_word),
        .hit_way (arr.hit_way),
        .new_op  (op),
        .new_bank(offset[OFFSET_W-1 -: BANK_W]),
        .arr     (arr.store),
        .conflict(conflict)
    );

    cache_ways u_ways (
        .clk   (clk),
        .resetn(resetn),
        .arr   (arr.ways)
    );

endmodule

// File: sim/mem_model.sv
`timescale 1ns/1ps

module mem_model import cache_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              rd_req,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic              rd_rdy,
    output logic              ret_valid,
    output logic              ret_last,
    output word_t             ret_data,
    input  logic              wr_req,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [LINE_W-1:0] wr_data,
    output logic              wr_rdy,
    output logic              align_err
);

    // sparse store, only lines that were written back
    logic [ADDR_W-OFFSET_W-1:0] line_addr_q [$];
    logic [LINE_W-1:0]          line_data_q [$];
    logic [31:0]                stall_state = 32'd7;
    logic [LINE_W-1:0]          ret_line;
    logic                       returning;
    int                         beat_idx;

    // same content as the reference model starts with
    function automatic word_t hash_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] stall_rand();
        stall_state = stall_state * 32'd1664525 + 32'd1013904223;
        return {stall_state[15:0], stall_state[31:16]};
    endfunction

    function automatic logic [LINE_W-1:0] read_line(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] line;
        for (int b = 0; b < NUM_BANKS; b++) begin
            line[b*WORD_W +: WORD_W] = hash_word({addr[ADDR_W-1:OFFSET_W], OFFSET_W'(b * 4)});
        end
        for (int i = 0; i < line_addr_q.size(); i++) begin
            if (line_addr_q[i] == addr[ADDR_W-1:OFFSET_W]) begin
                line = line_data_q[i];
            end
        end
        return line;
    endfunction

    task automatic write_line(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] line);
        logic found;
        found = 1'b0;
        for (int i = 0; i < line_addr_q.size(); i++) begin
            if (line_addr_q[i] == addr[ADDR_W-1:OFFSET_W]) begin
                line_data_q[i] = line;
                found = 1'b1;
            end
        end
        if (!found) begin
            line_addr_q.push_back(addr[ADDR_W-1:OFFSET_W]);
            line_data_q.push_back(line);
        end
    endtask

    initial begin : responder
        logic [31:0] r;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        align_err = 1'b0;
        returning = 1'b0;
        beat_idx  = 0;
        ret_line  = '0;
        forever begin
            @(negedge clk);  // handshakes are stable here
            if (!resetn) begin
                returning = 1'b0;
            end else begin
                if (ret_valid) begin
                    beat_idx++;
                    if (beat_idx == NUM_BANKS) begin
                        returning = 1'b0;
                    end
                end
                if (rd_req && rd_rdy) begin
                    if (rd_addr[OFFSET_W-1:0] != '0) begin
                        align_err = 1'b1;
                    end
                    ret_line  = read_line(rd_addr);
                    returning = 1'b1;
                    beat_idx  = 0;
                end
                if (wr_req && wr_rdy) begin
                    if (wr_addr[OFFSET_W-1:0] != '0) begin
                        align_err = 1'b1;
                    end
                    write_line(wr_addr, wr_data);
                end
            end
            @(posedge clk);
            #10;
            r = stall_rand();
            rd_rdy    = r[1:0] != 2'b00;  // ready three times in four
            wr_rdy    = r[3:2] != 2'b00;
            ret_valid = returning && r[5:4] != 2'b00;
            ret_last  = ret_valid && beat_idx == NUM_BANKS - 1;
            ret_data  = ret_valid ? ret_line[beat_idx*WORD_W +: WORD_W] : '0;
        end
    end

endmodule

// File: sim/tb_cache.sv
`timescale 1ns/1ps

module tb_cache import cache_pkg::*; ();

    localparam int NUM_RANDOM    = 2000;
    localparam int DIRECTED_REQS = 26;
    localparam int TOTAL_REQS    = NUM_RANDOM + DIRECTED_REQS;
    localparam int RESET_CYCLES  = 10;

    // four tags and four indexes, so sets fill up and evict
    localparam logic [4*TAG_W-1:0]   TAG_POOL   = {20'h00000, 20'hfff03, 20'h5a5a1, 20'h01234};
    localparam logic [4*INDEX_W-1:0] INDEX_POOL = {8'hff, 8'h81, 8'h3c, 8'h07};

    typedef struct packed {
        logic        is_load;
        logic        want_hit;
        word_t       exp;
        logic [31:0] acc_cycle;
    } pend_t;

    logic                clk;
    logic                resetn;
    logic                valid;
    logic                op;
    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] offset;
    logic [3:0]          wstrb;
    word_t               wdata;
    logic                addr_ok;
    logic                data_ok;
    word_t               rdata;
    logic                rd_req;
    logic [ADDR_W-1:0]   rd_addr;
    logic                rd_rdy;
    logic                ret_valid;
    logic                ret_last;
    word_t               ret_data;
    logic                wr_req;
    logic [ADDR_W-1:0]   wr_addr;
    logic [LINE_W-1:0]   wr_data;
    logic                wr_rdy;
    logic                align_err;

    logic [7:0]  ref_mem [256];  // 16 lines of 16 bytes
    pend_t       pend_q [$];
    logic [31:0] rng_state = 32'd7;
    int          cycle = 0;
    int          last_accept;
    int          wb_count = 0;
    int          err_count = 0;
    string       cur_test = "reset";

    cache_top uut (.*);

    mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic word_t hash_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {rng_state[15:0], rng_state[31:16]};  // low bits of an lcg are weak
    endfunction

    function automatic logic [31:0] make_addr(input int t, input int i, input int bank);
        return {TAG_POOL[t*TAG_W +: TAG_W], INDEX_POOL[i*INDEX_W +: INDEX_W], 2'(bank), 2'b00};
    endfunction

    function automatic int line_slot(input logic [31:0] addr);
        int slot;
        slot = -1;
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 4; i++) begin
                if (make_addr(t, i, 0) == {addr[31:4], 4'h0}) begin
                    slot = t * 4 + i;
                end
            end
        end
        return slot;
    endfunction

    function automatic word_t ref_word(input logic [31:0] addr);
        int base;
        base = line_slot(addr) * 16 + addr[3:0];
        return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
    endfunction

    function automatic logic [LINE_W-1:0] ref_line(input logic [31:0] addr);
        logic [LINE_W-1:0] line;
        int                slot;
        slot = line_slot(addr);
        for (int b = 0; b < 16; b++) begin
            line[b*8 +: 8] = ref_mem[slot*16 + b];
        end
        return line;
    endfunction

    task automatic ref_store(input logic [31:0] addr, input logic [3:0] strb, input word_t data);
        int base;
        base = line_slot(addr) * 16 + addr[3:0];
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                ref_mem[base+i] = data[i*8 +: 8];
            end
        end
    endtask

    task automatic init_ref();
        logic [31:0] base;
        word_t       w;
        for (int s = 0; s < 16; s++) begin
            base = make_addr(s / 4, s % 4, 0);
            for (int b = 0; b < 16; b++) begin
                w = hash_word(base + 32'(b & 12));
                ref_mem[s*16 + b] = w[(b % 4)*8 +: 8];
            end
        end
    endtask

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [LINE_W-1:0] exp,
                               input logic [LINE_W-1:0] act);
        if (act !== exp) begin
            err_count++;
            $display("Error in test %s, %s: expected %h, actual %h", cur_test, what, exp, act);
            abort_run();
        end
    endtask

    // holds the request until addr_ok, then records what data_ok must bring
    task automatic issue(input logic st, input logic [31:0] addr, input logic [3:0] strb,
                         input word_t data, input logic want_hit);
        pend_t ent;
        logic  done;
        done   = 1'b0;
        valid  = 1'b1;
        op     = st;
        tag    = addr[31:12];
        index  = addr[11:4];
        offset = addr[3:0];
        wstrb  = st ? strb : 4'h0;
        wdata  = data;
        while (!done) begin
            @(negedge clk);
            if (addr_ok) begin
                done          = 1'b1;
                last_accept   = cycle;
                ent.is_load   = !st;
                ent.want_hit  = want_hit;
                ent.exp       = st ? '0 : ref_word(addr);
                ent.acc_cycle = cycle;
                if (st) begin
                    ref_store(addr, strb, data);
                end
                pend_q.push_back(ent);
            end
            @(posedge clk);
            #10;
        end
        valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (pend_q.size() != 0) begin
            @(posedge clk);
            #10;
        end
    endtask

    always @(negedge clk) begin : response_check
        pend_t ent;
        if (resetn && data_ok) begin
            if (pend_q.size() == 0) begin
                $display("data_ok came with no request outstanding");
                abort_run();
            end else begin
                ent = pend_q.pop_front();
                if (ent.is_load) begin
                    check_value("load data", ent.exp, rdata);
                end
                if (!ent.is_load || ent.want_hit) begin
                    check_value("data_ok latency", 1, cycle - ent.acc_cycle);
                end
            end
        end
        if (resetn && wr_req && wr_rdy) begin
            if (line_slot(wr_addr) < 0) begin
                $display("writeback to a line the test never touched");
                abort_run();
            end else begin
                check_value("writeback line", ref_line(wr_addr), wr_data);
                wb_count++;
            end
        end
    end

    always @(posedge align_err) begin
        $display("memory request address is not line aligned");
        abort_run();
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + TOTAL_REQS * 200) @(posedge clk);
        $display("timeout, the cache did not finish all requests in time");
        abort_run();
    end

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] r;
        word_t       data;
        int          first_accept;
        int          prev_wb;
        resetn = 1'b0;
        valid  = 1'b0;
        op     = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        init_ref();
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        // handshake and memory requests stay quiet while in reset
        check_value("outputs in reset", 4'h0, {addr_ok, data_ok, rd_req, wr_req});
        resetn = 1'b1;

        cur_test = "cold load miss";
        for (int i = 0; i < 4; i++) begin
            issue(1'b0, make_addr(i, i, i), 4'h0, '0, 1'b0);
            wait_drained();
        end

        cur_test = "hit latency";
        issue(1'b0, make_addr(0, 0, 0), 4'h0, '0, 1'b1);
        wait_drained();
        for (int b = 0; b < NUM_BANKS; b++) begin
            issue(1'b0, make_addr(0, 0, b), 4'h0, '0, 1'b1);
            if (b == 0) begin
                first_accept = last_accept;
            end else begin
                check_value("back to back accept", first_accept + b, last_accept);
            end
        end
        wait_drained();

        // lines 0 and 1 are resident, the last two pairs were never loaded
        cur_test = "partial store";
        for (int k = 0; k < 4; k++) begin
            addr = (k < 2) ? make_addr(k, k, k + 1) : make_addr(k - 1, k, k);
            r    = next_rand();
            data = next_rand();
            issue(1'b1, addr, r[3:0], data, 1'b0);
            issue(1'b0, addr, 4'h0, '0, 1'b0);
            wait_drained();
        end

        cur_test = "dirty eviction";
        prev_wb  = wb_count;
        for (int round = 0; round < 2; round++) begin
            for (int t = 1; t < 4; t++) begin
                data = next_rand();
                issue(1'b1, make_addr(t, 1, t), 4'hf, data, 1'b0);
            end
        end
        wait_drained();
        check_value("writeback seen", 1, wb_count > prev_wb);
        for (int t = 1; t < 4; t++) begin
            issue(1'b0, make_addr(t, 1, t), 4'h0, '0, 1'b0);
        end
        wait_drained();

        cur_test = "random mix";
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r    = next_rand();
            data = next_rand();
            addr = make_addr(r[1:0], r[3:2], r[5:4]);
            issue(r[6], addr, r[11:8], data, 1'b0);
        end
        wait_drained();

        if (err_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// File: compile.f
verilog/cache_pkg.sv
verilog/cache_array_if.sv
verilog/cache_ram.sv
verilog/cache_ways.sv
verilog/cache_ctrl.sv
verilog/refill_counter.sv
verilog/store_buffer.sv
verilog/cache_top.sv
sim/mem_model.sv
sim/tb_cache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - verilog/cache_pkg.sv
  - verilog/cache_array_if.sv
  - verilog/cache_ram.sv
  - verilog/cache_ways.sv
  - verilog/cache_ctrl.sv
  - verilog/refill_counter.sv
  - verilog/store_buffer.sv
  - verilog/cache_top.sv
  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/tb_cache.sv
